/* rtl/adc_ctrl_pkg.sv */
package adc_ctrl_pkg;

  //////////////////////////////////////////////////
  // ADS8168 timing on a 20 MHz clock
  //////////////////////////////////////////////////
  localparam int T_CONV_NS    = 660;         // Conversion time
  localparam int T_CYCLE_NS   = 1000;        // Minimum cycle time
  localparam int SPI_CLK_HZ   = 20_000_000;
  localparam int CLK_MHZ      = SPI_CLK_HZ / 1_000_000;
  localparam int CONV_CYCLES  = (T_CONV_NS * CLK_MHZ + 999) / 1000;   // Rounded up, 14
  localparam int CYCLE_CYCLES = (T_CYCLE_NS * CLK_MHZ + 999) / 1000;  // Rounded up, 20
  localparam int FRAME_BITS   = 16;          // One on-the-fly frame
  // n_cs high time covers both the conversion and the rest of the cycle
  localparam int CS_HIGH_CYCLES = (CONV_CYCLES > CYCLE_CYCLES - FRAME_BITS) ?
                                  CONV_CYCLES : (CYCLE_CYCLES - FRAME_BITS);
  localparam int CS_CNT_W     = $clog2(CS_HIGH_CYCLES);
  localparam int BIT_CNT_W    = $clog2(FRAME_BITS);
  localparam int N_CHANNELS   = 8;
  localparam int N_FRAMES     = N_CHANNELS + 1;  // Last frame flushes the final result

  // Command word fields
  localparam int OP_LSB   = 30;  // Opcode in 31:30
  localparam int TRIG_BIT = 29;
  localparam int CONT_BIT = 28;
  localparam int DELAY_W  = 26;  // Delay in 25:0

  localparam logic [1:0] OTF_PREFIX = 2'b10;  // On-the-fly request header

  typedef logic [31:0] cmd_word_t;
  typedef logic [31:0] data_word_t;
  typedef logic [15:0] sample_t;
  typedef logic [2:0]  chan_t;
  typedef logic [DELAY_W-1:0] delay_t;
  typedef logic [3:0]  frame_idx_t;

  typedef enum logic [1:0] {
    OP_NOP     = 2'b00,
    OP_ADC_RD  = 2'b01,
    OP_SET_ORD = 2'b10,
    OP_CANCEL  = 2'b11
  } cmd_op_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_DELAY, ST_TRIG_WAIT, ST_ADC_RD, ST_ERROR
  } seq_state_e;

  typedef struct packed {
    chan_t [N_CHANNELS-1:0] slot;  // Slot 0 in the low bits
  } chan_order_t;

  typedef struct packed {
    logic  start;    // One-cycle request
    chan_t chan;
    logic  capture;  // Keep the sample this frame returns
  } frame_req_t;

  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_beat_t;

  typedef struct packed {
    logic unexp_trig;
    logic cmd_buf_underflow;
    logic data_buf_overflow;
  } err_flags_t;

endpackage

/* rtl/chan_order_reg.sv */
`timescale 1ns/1ps

module chan_order_reg (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      load,      // SET_ORD accepted
  input  adc_ctrl_pkg::cmd_word_t   cmd_word,
  output adc_ctrl_pkg::chan_order_t order
);
  import adc_ctrl_pkg::*;

  // Identity order out of reset, slots packed 3 bits each from bit 0
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < N_CHANNELS; i++) begin
        order.slot[i] <= chan_t'(i);  // Slot k reads channel k
      end
    end else if (load) begin
      order <= chan_order_t'(cmd_word[$bits(chan_order_t)-1:0]);
    end
  end

endmodule

/* rtl/cmd_sequencer.sv */
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                      clk,
  input  logic                      resetn,
  input  adc_ctrl_pkg::cmd_word_t   cmd_word,
  input  logic                      cmd_buf_empty,
  input  logic                      trigger,
  output logic                      cmd_word_rd_en,
  input  adc_ctrl_pkg::chan_order_t order,
  output logic                      order_load,
  output adc_ctrl_pkg::frame_req_t  frame_req,
  input  logic                      frame_done,
  input  logic                      overflow,
  output logic                      halt,
  output logic                      waiting_for_trig,
  output adc_ctrl_pkg::err_flags_t  err
);
  import adc_ctrl_pkg::*;

  seq_state_e state;
  seq_state_e accept_state;  // Where the head command leads
  cmd_op_e    op;            // Opcode at the buffer head
  logic       wait_trig;     // Trigger bit of the running command
  logic       expect_next;   // Continue bit of the running command
  delay_t     delay_timer;
  frame_idx_t frame_idx;
  frame_idx_t next_idx;
  logic       last_frame;
  logic       cmd_done;
  logic       cancel_wait;
  logic       accept;
  err_flags_t err_set;       // Errors seen this cycle
  logic       any_err;

  assign op = cmd_op_e'(cmd_word[OP_LSB +: 2]);

  //////////////////////////////////////////////////
  // Command finish, cancel and accept
  //////////////////////////////////////////////////
  assign cmd_done = (state == ST_DELAY && delay_timer == '0)
                    || (state == ST_TRIG_WAIT && trigger);
  // A queued CANCEL cuts a wait short
  assign cancel_wait = (state == ST_DELAY || state == ST_TRIG_WAIT)
                       && !cmd_buf_empty && op == OP_CANCEL;

  assign err_set.unexp_trig        = trigger && state != ST_TRIG_WAIT;
  assign err_set.cmd_buf_underflow = cmd_done && expect_next && cmd_buf_empty;
  assign err_set.data_buf_overflow = overflow;
  assign any_err = |err_set;

  // Take the head word when idle or when the running command ends
  assign accept = !cmd_buf_empty && !any_err && (state == ST_IDLE || cmd_done);
  assign cmd_word_rd_en = accept || (cancel_wait && !any_err);
  assign order_load     = accept && op == OP_SET_ORD;

  always_comb begin
    case (op)
      OP_NOP:    accept_state = cmd_word[TRIG_BIT] ? ST_TRIG_WAIT : ST_DELAY;
      OP_ADC_RD: accept_state = ST_ADC_RD;
      default:   accept_state = ST_IDLE;  // SET_ORD and a stray CANCEL
    endcase
  end

  // State register
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_IDLE;
    end else if (any_err) begin
      state <= ST_ERROR;  // Only reset leaves
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) state <= accept_state;
        end
        ST_DELAY, ST_TRIG_WAIT: begin
          if (cancel_wait)   state <= ST_IDLE;
          else if (accept)   state <= accept_state;  // Chain straight on
          else if (cmd_done) state <= ST_IDLE;
        end
        ST_ADC_RD: begin
          // Frames done, finish as a trigger wait or the rest of the delay
          if (frame_done && last_frame) state <= wait_trig ? ST_TRIG_WAIT : ST_DELAY;
        end
        default: state <= ST_ERROR;
      endcase
    end
  end

  // Trigger and continue bits of the accepted command
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (accept) begin
      wait_trig   <= (op == OP_NOP || op == OP_ADC_RD) && cmd_word[TRIG_BIT];
      expect_next <= (op == OP_NOP || op == OP_ADC_RD) && cmd_word[CONT_BIT];
    end else if (cancel_wait) begin
      expect_next <= 1'b0;  // Cancelled command expects nothing
    end
  end

  // Delay runs from accept, also through the ADC frames
  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_timer <= '0;
    end else if (accept && (op == OP_NOP || op == OP_ADC_RD)) begin
      delay_timer <= cmd_word[DELAY_W-1:0];
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Frame requests
  //////////////////////////////////////////////////
  assign last_frame = (frame_idx == frame_idx_t'(N_FRAMES - 1));
  assign next_idx   = (state == ST_ADC_RD) ? frame_idx + 1'b1 : '0;  // Zero on accept

  assign frame_req.start = (accept && op == OP_ADC_RD)
                           || (state == ST_ADC_RD && frame_done && !last_frame && !any_err);
  assign frame_req.chan    = order.slot[next_idx[$bits(chan_t)-1:0]];  // Frame 8 wraps to slot 0
  assign frame_req.capture = (next_idx != '0);  // Frame 0 returns stale data

  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_idx <= '0;
    end else if (accept && op == OP_ADC_RD) begin
      frame_idx <= '0;
    end else if (state == ST_ADC_RD && frame_done && !last_frame) begin
      frame_idx <= next_idx;
    end
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (!resetn) err <= '0;
    else         err <= err | err_set;
  end

  assign halt             = (state == ST_ERROR);
  assign waiting_for_trig = (state == ST_TRIG_WAIT);

endmodule

/* rtl/spi_frame_engine.sv */
`timescale 1ns/1ps

module spi_frame_engine (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       halt,
  input  adc_ctrl_pkg::frame_req_t   frame_req,
  output logic                       frame_done,
  output adc_ctrl_pkg::sample_beat_t beat,
  output logic                       n_cs,
  output logic                       mosi,
  input  logic                       miso
);
  import adc_ctrl_pkg::*;

  logic                  cs_wait;    // Holding n_cs high before the frame
  logic [CS_CNT_W-1:0]   cs_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;    // Bits left in the frame
  logic [FRAME_BITS-1:0] mosi_sr;
  logic [FRAME_BITS-2:0] miso_sr;    // Last bit joins straight from the pin
  logic                  capture_q;
  logic                  last_bit;

  assign last_bit = !n_cs && bit_cnt == '0;
  assign mosi     = mosi_sr[FRAME_BITS-1];  // MSB first

  //////////////////////////////////////////////////
  // Chip select and bit timing
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      n_cs       <= 1'b1;  // Parked
      cs_wait    <= 1'b0;
      cs_cnt     <= '0;
      bit_cnt    <= '0;
      capture_q  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= last_bit;  // Lands with the n_cs rise
      if (frame_req.start) begin
        cs_wait   <= 1'b1;
        cs_cnt    <= CS_CNT_W'(CS_HIGH_CYCLES - 1);
        capture_q <= frame_req.capture;
      end else if (cs_wait) begin
        if (cs_cnt == '0) begin
          cs_wait <= 1'b0;
          n_cs    <= 1'b0;  // Frame starts
          bit_cnt <= BIT_CNT_W'(FRAME_BITS - 1);
        end else begin
          cs_cnt <= cs_cnt - 1'b1;
        end
      end else if (!n_cs) begin
        if (last_bit) n_cs <= 1'b1;
        else          bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  // Request word loaded at start, shifted while selected
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mosi_sr <= '0;
    end else if (frame_req.start) begin
      mosi_sr <= {OTF_PREFIX, frame_req.chan, {(FRAME_BITS - 5){1'b0}}};
    end else if (!n_cs) begin
      mosi_sr <= {mosi_sr[FRAME_BITS-2:0], 1'b0};
    end
  end

  // MISO sampled on every selected edge
  always_ff @(posedge clk) begin
    if (!n_cs) miso_sr <= {miso_sr[FRAME_BITS-3:0], miso};
  end

  // Sample out in the cycle n_cs rises
  always_ff @(posedge clk) begin
    if (last_bit) beat.data <= {miso_sr, miso};
    if (!resetn || halt) beat.valid <= 1'b0;
    else                 beat.valid <= last_bit && capture_q;
  end

endmodule

/* rtl/sample_packer.sv */
`timescale 1ns/1ps

module sample_packer (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       halt,
  input  adc_ctrl_pkg::sample_beat_t beat,
  input  logic                       data_buf_full,
  output logic                       data_word_wr_en,
  output adc_ctrl_pkg::data_word_t   data_word,
  output logic                       overflow
);
  import adc_ctrl_pkg::*;

  logic    have_low;  // Even beat held, waiting for its partner
  logic    pend;      // Word ready this cycle
  sample_t hold;

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      have_low <= 1'b0;
      pend     <= 1'b0;
    end else begin
      pend <= beat.valid && have_low;  // Odd beat completes a pair
      if (beat.valid) have_low <= !have_low;
    end
  end

  // Low half first, new beat on top
  always_ff @(posedge clk) begin
    if (beat.valid && !have_low) hold <= beat.data;
    if (beat.valid && have_low) data_word <= {beat.data, hold};
  end

  // No back-pressure, a full buffer drops the word and flags it
  assign data_word_wr_en = pend && !data_buf_full;
  assign overflow        = pend && data_buf_full;

endmodule

/* rtl/adc_ctrl_top.sv */
`timescale 1ns/1ps

module adc_ctrl_top (
  input  logic                     clk,
  input  logic                     resetn,
  // Command buffer, FWFT
  input  adc_ctrl_pkg::cmd_word_t  cmd_word,
  input  logic                     cmd_buf_empty,
  output logic                     cmd_word_rd_en,
  // Data buffer
  output logic                     data_word_wr_en,
  output adc_ctrl_pkg::data_word_t data_word,
  input  logic                     data_buf_full,
  input  logic                     trigger,
  output logic                     waiting_for_trig,
  output adc_ctrl_pkg::err_flags_t err,
  // ADC SPI
  output logic                     n_cs,
  output logic                     mosi,
  input  logic                     miso
);
  import adc_ctrl_pkg::*;

  chan_order_t  order;
  logic         order_load;
  frame_req_t   frame_req;
  logic         frame_done;
  sample_beat_t beat;
  logic         overflow;
  logic         halt;       // High in the error state

  chan_order_reg u_order (
    .clk      (clk),
    .resetn   (resetn),
    .load     (order_load),
    .cmd_word (cmd_word),
    .order    (order)
  );

  cmd_sequencer u_seq (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_word         (cmd_word),
    .cmd_buf_empty    (cmd_buf_empty),
    .trigger          (trigger),
    .cmd_word_rd_en   (cmd_word_rd_en),
    .order            (order),
    .order_load       (order_load),
    .frame_req        (frame_req),
    .frame_done       (frame_done),
    .overflow         (overflow),
    .halt             (halt),
    .waiting_for_trig (waiting_for_trig),
    .err              (err)
  );

  spi_frame_engine u_spi (
    .clk        (clk),
    .resetn     (resetn),
    .halt       (halt),
    .frame_req  (frame_req),
    .frame_done (frame_done),
    .beat       (beat),
    .n_cs       (n_cs),
    .mosi       (mosi),
    .miso       (miso)
  );

  sample_packer u_pack (
    .clk             (clk),
    .resetn          (resetn),
    .halt            (halt),
    .beat            (beat),
    .data_buf_full   (data_buf_full),
    .data_word_wr_en (data_word_wr_en),
    .data_word       (data_word),
    .overflow        (overflow)
  );

endmodule

/* tests/adc_ctrl_props.sv */
`timescale 1ns/1ps

module adc_ctrl_props (
  input logic clk,
  input logic resetn,
  input logic halt,
  input logic n_cs,
  input logic cmd_word_rd_en,
  input logic cmd_buf_empty
);
  import adc_ctrl_pkg::*;

  int unsigned low_cnt;  // Selected edges in the current frame

  always_ff @(posedge clk) begin
    if (!resetn || n_cs) low_cnt <= 0;
    else                 low_cnt <= low_cnt + 1;
  end

  // Frame length exact
  frame_len_a: assert property (@(posedge clk) disable iff (!resetn || halt)
    $rose(n_cs) |-> low_cnt == FRAME_BITS)
    else $error("n_cs low time differs from the frame length");

  // Parked one cycle after halt
  halt_cs_a: assert property (@(posedge clk) disable iff (!resetn)
    halt && $past(halt) |-> n_cs)
    else $error("n_cs low while halted");

  rd_empty_a: assert property (@(posedge clk) disable iff (!resetn)
    cmd_word_rd_en |-> !cmd_buf_empty)
    else $error("command read from an empty buffer");

endmodule

bind spi_frame_engine adc_ctrl_props props_spi (
  .clk(clk), .resetn(resetn), .halt(halt), .n_cs(n_cs),
  .cmd_word_rd_en(1'b0), .cmd_buf_empty(1'b0)
);

bind cmd_sequencer adc_ctrl_props props_seq (
  .clk(clk), .resetn(resetn), .halt(halt), .n_cs(1'b1),
  .cmd_word_rd_en(cmd_word_rd_en), .cmd_buf_empty(cmd_buf_empty)
);

/* tests/adc_ctrl_tb.sv */
`timescale 1ns/1ps

module adc_ctrl_tb;
  import adc_ctrl_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int N_CMDS         = 12;    // Commands issued over the whole run
  localparam int MAX_CMD_CYCLES = 1000;  // Longest command incl. settle time
  localparam int WATCHDOG_NS    = N_CMDS * MAX_CMD_CYCLES * CLK_PERIOD;

  logic        clk;
  logic        resetn;
  cmd_word_t   cmd_word;
  logic        cmd_buf_empty;
  logic        cmd_word_rd_en;
  logic        data_word_wr_en;
  data_word_t  data_word;
  logic        data_buf_full;
  logic        trigger;
  logic        waiting_for_trig;
  err_flags_t  err;
  logic        n_cs;
  logic        mosi;
  logic        miso;

  cmd_word_t   cmd_q[$];       // FWFT command buffer model
  data_word_t  cap_q[$];       // Words written to the data buffer
  chan_t       frame_chan[$];  // Channel decoded from each MOSI frame
  sample_t     frame_ans[$];   // Value the ADC returned in each frame
  chan_order_t model_order;
  logic [15:0] mosi_sr;
  sample_t     ans;
  int          bit_pos;
  int          errors;
  int          n_cs_low_cnt;
  logic        rd_seen;

  adc_ctrl_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Buffer and ADC models
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    rd_seen = cmd_word_rd_en;  // Consumed at the coming edge
    if (cmd_word_rd_en === 1'b1 && cmd_buf_empty) begin
      errors++;
      $display("Error: time %0t, command read while the buffer is empty", $time);
    end
    if (data_word_wr_en === 1'b1) begin
      cap_q.push_back(data_word);
      if (data_buf_full) begin
        errors++;
        $display("Error: time %0t, data word written while the buffer is full", $time);
      end
    end
    if (n_cs === 1'b0) begin
      mosi_sr = {mosi_sr[14:0], mosi};  // Value the ADC latches at the next edge
      n_cs_low_cnt++;
    end
  end

  // Head of the queue shows after the pop
  always @(posedge clk) begin
    #2;
    if (rd_seen === 1'b1 && cmd_q.size() > 0) void'(cmd_q.pop_front());
    cmd_buf_empty = (cmd_q.size() == 0);
    cmd_word      = cmd_buf_empty ? '0 : cmd_q[0];
  end

  // Fresh random answer per frame, MSB first
  always @(posedge clk) begin
    #1;
    if (n_cs === 1'b0) begin
      if (bit_pos == 0) begin
        ans = sample_t'($urandom);
        frame_ans.push_back(ans);
      end
      miso = ans[15 - bit_pos];
      bit_pos++;
    end else begin
      if (bit_pos == FRAME_BITS) begin
        frame_chan.push_back(mosi_sr[13:11]);
        check("mosi_prefix", 32'(mosi_sr[15:14]), 32'b10);
        check("mosi_pad", 32'(mosi_sr[10:0]), 32'd0);
      end
      bit_pos = 0;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error: time %0t, %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error: time %0t, %s", $time, what);
  endtask

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  function automatic cmd_word_t make_cmd(input cmd_op_e op, input logic trig,
                                         input logic cont, input delay_t dly);
    return {op, trig, cont, 2'b00, dly};
  endfunction

  task automatic apply_reset();
    resetn        = 1'b0;
    trigger       = 1'b0;
    data_buf_full = 1'b0;
    cmd_q.delete();
    frame_chan.delete();  // Frames cut short by a halt are dropped
    frame_ans.delete();
    step(4);
    resetn = 1'b1;
    for (int i = 0; i < N_CHANNELS; i++) model_order.slot[i] = chan_t'(i);
  endtask

  task automatic wait_words(input int n, input int limit);
    int c;
    c = 0;
    while (cap_q.size() < n && c < limit) begin
      step(1);
      c++;
    end
    if (cap_q.size() < n) report_failure("data words did not arrive in time");
  endtask

  task automatic wait_drained(input int limit);
    int c;
    c = 0;
    while (cmd_q.size() != 0 && c < limit) begin
      step(1);
      c++;
    end
    if (cmd_q.size() != 0) report_failure("commands were not consumed in time");
  endtask

  task automatic wait_trig_level(input logic level, input int limit);
    int c;
    c = 0;
    while (waiting_for_trig !== level && c < limit) begin
      step(1);
      c++;
    end
    check("waiting_for_trig", 32'(waiting_for_trig), 32'(level));
  endtask

  task automatic wait_err(input err_flags_t mask, input int limit);
    int c;
    c = 0;
    while ((err & mask) == '0 && c < limit) begin
      step(1);
      c++;
    end
    check("err", 32'(err), 32'(mask));
  endtask

  // Reference: frame k asks slot k mod 8, frame k+1 returns the slot k result
  task automatic run_adc_read();
    int f0;
    int w0;
    f0 = frame_chan.size();
    w0 = cap_q.size();
    cmd_q.push_back(make_cmd(OP_ADC_RD, 1'b0, 1'b0, '0));
    wait_words(w0 + 4, MAX_CMD_CYCLES);
    step(2);
    if (frame_chan.size() < f0 + N_FRAMES || cap_q.size() < w0 + 4) begin
      report_failure("ADC read returned too few frames or words");
    end else begin
      for (int k = 0; k < N_FRAMES; k++)
        check("mosi_chan", 32'(frame_chan[f0 + k]), 32'(model_order.slot[k % N_CHANNELS]));
      for (int i = 0; i < 4; i++)
        check("data_word", cap_q[w0 + i],
              {frame_ans[f0 + 2 * i + 2], frame_ans[f0 + 2 * i + 1]});
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'hda31));
    errors        = 0;
    n_cs_low_cnt  = 0;
    bit_pos       = 0;
    mosi_sr       = '0;
    ans           = '0;
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    data_buf_full = 1'b0;
    trigger       = 1'b0;
    miso          = 1'b0;
    resetn        = 1'b0;
    apply_reset();

    run_adc_read();  // Default order

    // Random order then a read
    for (int i = 0; i < N_CHANNELS; i++) model_order.slot[i] = chan_t'($urandom);
    cmd_q.push_back({OP_SET_ORD, 6'b0, 24'(model_order)});
    run_adc_read();

    // Delay, then trigger wait; marker must stay queued
    cmd_q.push_back(make_cmd(OP_NOP, 1'b0, 1'b0, delay_t'(30)));
    cmd_q.push_back(make_cmd(OP_NOP, 1'b1, 1'b0, '0));
    cmd_q.push_back(make_cmd(OP_NOP, 1'b0, 1'b0, '0));
    wait_trig_level(1'b1, 200);
    step(10);
    check("cmd_q_size", 32'(cmd_q.size()), 32'd1);
    trigger = 1'b1;
    step(1);
    trigger = 1'b0;
    wait_trig_level(1'b0, 10);
    wait_drained(10);

    // Long delay cut short by CANCEL
    cmd_q.push_back(make_cmd(OP_NOP, 1'b0, 1'b0, delay_t'(100000)));
    cmd_q.push_back(make_cmd(OP_CANCEL, 1'b0, 1'b0, '0));
    cmd_q.push_back(make_cmd(OP_NOP, 1'b0, 1'b0, '0));
    wait_drained(50);
    step(5);

    // Trigger while idle halts everything
    trigger = 1'b1;
    step(1);
    trigger = 1'b0;
    wait_err('{unexp_trig: 1'b1, cmd_buf_underflow: 1'b0, data_buf_overflow: 1'b0}, 10);
    n_cs_low_cnt = 0;
    cmd_q.push_back(make_cmd(OP_ADC_RD, 1'b0, 1'b0, '0));
    step(100);
    check("cmd_q_size", 32'(cmd_q.size()), 32'd1);
    check("n_cs_low_cycles", 32'(n_cs_low_cnt), 32'd0);

    // Continue bit with nothing behind it
    apply_reset();
    cmd_q.push_back(make_cmd(OP_NOP, 1'b0, 1'b1, delay_t'(5)));
    wait_err('{unexp_trig: 1'b0, cmd_buf_underflow: 1'b1, data_buf_overflow: 1'b0}, 100);

    // Full data buffer during a read
    apply_reset();
    data_buf_full = 1'b1;
    begin
      int w0;
      w0 = cap_q.size();
      cmd_q.push_back(make_cmd(OP_ADC_RD, 1'b0, 1'b0, '0));
      wait_err('{unexp_trig: 1'b0, cmd_buf_underflow: 1'b0, data_buf_overflow: 1'b1},
               MAX_CMD_CYCLES);
      check("words_while_full", 32'(cap_q.size()), 32'(w0));
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* list.f */
rtl/adc_ctrl_pkg.sv
rtl/chan_order_reg.sv
rtl/cmd_sequencer.sv
rtl/spi_frame_engine.sv
rtl/sample_packer.sv
rtl/adc_ctrl_top.sv
tests/adc_ctrl_props.sv
tests/adc_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module adc_ctrl_tb -o adc_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/adc_ctrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1
